//--- source/mips_id_pkg.sv
`default_nettype none

package mips_id_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	// ALU operation codes as seen by EX
	typedef enum logic [7:0] {
		ALU_NOP    = 8'b0000_0000,
		ALU_OR     = 8'b0010_0101,
		ALU_AND    = 8'b0010_0100,
		ALU_XOR    = 8'b0010_0110,
		ALU_NOR    = 8'b0010_0111,
		ALU_SLL    = 8'b0111_1100,
		ALU_SRL    = 8'b0000_0010,
		ALU_SRA    = 8'b0000_0011,
		ALU_SLT    = 8'b0010_1010,
		ALU_SLTU   = 8'b0010_1011,
		ALU_ADD    = 8'b0010_0000,
		ALU_ADDU   = 8'b0010_0001,
		ALU_ADDI   = 8'b0101_0101,
		ALU_ADDIU  = 8'b0101_0110,
		ALU_SUB    = 8'b0010_0010,
		ALU_SUBU   = 8'b0010_0011,
		ALU_J      = 8'b0100_1111,
		ALU_JAL    = 8'b0101_0000,
		ALU_JR     = 8'b0000_1000,
		ALU_JALR   = 8'b0000_1001,
		ALU_BEQ    = 8'b0101_0001,
		ALU_BNE    = 8'b0101_0010,
		ALU_BGTZ   = 8'b0101_0100,
		ALU_BLEZ   = 8'b0101_0011,
		ALU_BGEZ   = 8'b0100_0001,
		ALU_BGEZAL = 8'b0100_1011,
		ALU_BLTZ   = 8'b0100_0000,
		ALU_BLTZAL = 8'b0100_1010
	} aluop_e;

	typedef enum logic [2:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_SHIFT       = 3'b010,
		SEL_ARITH       = 3'b100,
		SEL_JUMP_BRANCH = 3'b110
	} alusel_e;

	typedef enum logic [3:0] {
		BR_NONE,
		BR_JUMP_ABS,
		BR_JUMP_REG,
		BR_EQ,
		BR_NE,
		BR_GTZ,
		BR_LEZ,
		BR_GEZ,
		BR_LTZ
	} br_kind_e;

	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_REGIMM  = 6'b000001;
	localparam logic [5:0] OP_J       = 6'b000010;
	localparam logic [5:0] OP_JAL     = 6'b000011;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;
	localparam logic [5:0] OP_BLEZ    = 6'b000110;
	localparam logic [5:0] OP_BGTZ    = 6'b000111;
	localparam logic [5:0] OP_ADDI    = 6'b001000;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_SLTI    = 6'b001010;
	localparam logic [5:0] OP_SLTIU   = 6'b001011;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;

	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_JR   = 6'b001000;
	localparam logic [5:0] FN_JALR = 6'b001001;
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	// rt field of REGIMM
	localparam logic [4:0] RT_BLTZ   = 5'b00000;
	localparam logic [4:0] RT_BGEZ   = 5'b00001;
	localparam logic [4:0] RT_BLTZAL = 5'b10000;
	localparam logic [4:0] RT_BGEZAL = 5'b10001;

	localparam reg_addr_t LINK_REG = 5'd31;

	typedef struct packed {
		aluop_e    aluop;
		alusel_e   alusel;
		logic      reg1_rd;
		logic      reg2_rd;
		reg_addr_t reg1_addr;
		reg_addr_t reg2_addr;
		reg_addr_t wd;
		logic      wreg;
		word_t     imm;
		br_kind_e  br_kind;
		logic      link;
	} decode_t;

	typedef struct packed {
		logic      wreg;
		reg_addr_t wd;
		word_t     wdata;
	} fwd_t;

	typedef struct packed {
		logic  flag;
		word_t target;
		logic  next_in_dslot;
	} branch_t;

	typedef struct packed {
		aluop_e    aluop;
		alusel_e   alusel;
		word_t     op1;
		word_t     op2;
		reg_addr_t wd;
		logic      wreg;
		word_t     link_addr;
		logic      in_dslot;
	} id_ex_t;

endpackage

`default_nettype wire

//--- source/id_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module id_decoder (
	input  mips_id_pkg::word_t   inst_i,
	output mips_id_pkg::decode_t dec_o
);
	import mips_id_pkg::*;

	logic [5:0] op;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;
	logic [4:0] shamt;
	logic [5:0] funct;
	logic [15:0] imm16;

	assign op    = inst_i[31:26];
	assign rs    = inst_i[25:21];
	assign rt    = inst_i[20:16];
	assign rd    = inst_i[15:11];
	assign shamt = inst_i[10:6];
	assign funct = inst_i[5:0];
	assign imm16 = inst_i[15:0];

	function automatic alusel_e class_of(input aluop_e aluop);
		case (aluop)
			ALU_NOP: class_of = SEL_NOP;
			ALU_OR, ALU_AND, ALU_XOR, ALU_NOR: class_of = SEL_LOGIC;
			ALU_SLL, ALU_SRL, ALU_SRA: class_of = SEL_SHIFT;
			ALU_SLT, ALU_SLTU, ALU_ADD, ALU_ADDU, ALU_ADDI, ALU_ADDIU,
			ALU_SUB, ALU_SUBU: class_of = SEL_ARITH;
			default: class_of = SEL_JUMP_BRANCH;
		endcase
	endfunction

	always_comb begin
		dec_o = '0;
		dec_o.reg1_addr = rs;
		dec_o.reg2_addr = rt;
		dec_o.wd = rd;
		case (op)
			OP_SPECIAL: begin
				dec_o.reg1_rd = 1'b1;
				dec_o.reg2_rd = 1'b1;
				dec_o.wreg = 1'b1;
				case (funct)
					FN_OR:   dec_o.aluop = ALU_OR;
					FN_AND:  dec_o.aluop = ALU_AND;
					FN_XOR:  dec_o.aluop = ALU_XOR;
					FN_NOR:  dec_o.aluop = ALU_NOR;
					FN_SLLV: dec_o.aluop = ALU_SLL;
					FN_SRLV: dec_o.aluop = ALU_SRL;
					FN_SRAV: dec_o.aluop = ALU_SRA;
					FN_SLT:  dec_o.aluop = ALU_SLT;
					FN_SLTU: dec_o.aluop = ALU_SLTU;
					FN_ADD:  dec_o.aluop = ALU_ADD;
					FN_ADDU: dec_o.aluop = ALU_ADDU;
					FN_SUB:  dec_o.aluop = ALU_SUB;
					FN_SUBU: dec_o.aluop = ALU_SUBU;
					FN_SLL, FN_SRL, FN_SRA: begin
						dec_o.aluop = (funct == FN_SLL) ? ALU_SLL :
							(funct == FN_SRL) ? ALU_SRL : ALU_SRA;
						dec_o.reg1_rd = 1'b0; // shamt goes through op1
						dec_o.imm = {27'd0, shamt};
					end
					FN_JR: begin
						dec_o.aluop = ALU_JR;
						dec_o.reg2_rd = 1'b0;
						dec_o.wreg = 1'b0;
						dec_o.br_kind = BR_JUMP_REG;
					end
					FN_JALR: begin
						dec_o.aluop = ALU_JALR;
						dec_o.reg2_rd = 1'b0;
						dec_o.wreg = (rd != '0); // link into r0 is dropped
						dec_o.br_kind = BR_JUMP_REG;
						dec_o.link = 1'b1;
					end
					default: begin
						dec_o.reg1_rd = 1'b0;
						dec_o.reg2_rd = 1'b0;
						dec_o.wreg = 1'b0;
					end
				endcase
			end
			OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				dec_o.reg1_rd = 1'b1;
				dec_o.wreg = 1'b1;
				dec_o.wd = rt;
				case (op)
					OP_ANDI:        dec_o.aluop = ALU_AND;
					OP_ORI, OP_LUI: dec_o.aluop = ALU_OR;
					OP_XORI:        dec_o.aluop = ALU_XOR;
					OP_ADDI:        dec_o.aluop = ALU_ADDI;
					OP_ADDIU:       dec_o.aluop = ALU_ADDIU;
					OP_SLTI:        dec_o.aluop = ALU_SLT;
					default:        dec_o.aluop = ALU_SLTU;
				endcase
				if (op == OP_LUI) begin
					dec_o.imm = {imm16, 16'h0000};
				end else if (op[5:2] == 4'b0011) begin // andi, ori, xori
					dec_o.imm = {16'h0000, imm16};
				end else begin
					dec_o.imm = {{16{imm16[15]}}, imm16};
				end
			end
			OP_J: begin
				dec_o.aluop = ALU_J;
				dec_o.br_kind = BR_JUMP_ABS;
			end
			OP_JAL: begin
				dec_o.aluop = ALU_JAL;
				dec_o.br_kind = BR_JUMP_ABS;
				dec_o.wd = LINK_REG;
				dec_o.wreg = 1'b1;
				dec_o.link = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				dec_o.aluop = (op == OP_BEQ) ? ALU_BEQ : ALU_BNE;
				dec_o.br_kind = (op == OP_BEQ) ? BR_EQ : BR_NE;
				dec_o.reg1_rd = 1'b1;
				dec_o.reg2_rd = 1'b1;
			end
			OP_BGTZ, OP_BLEZ: begin
				dec_o.aluop = (op == OP_BGTZ) ? ALU_BGTZ : ALU_BLEZ;
				dec_o.br_kind = (op == OP_BGTZ) ? BR_GTZ : BR_LEZ;
				dec_o.reg1_rd = 1'b1;
			end
			OP_REGIMM: begin
				case (rt)
					RT_BLTZ:   dec_o.aluop = ALU_BLTZ;
					RT_BGEZ:   dec_o.aluop = ALU_BGEZ;
					RT_BLTZAL: dec_o.aluop = ALU_BLTZAL;
					RT_BGEZAL: dec_o.aluop = ALU_BGEZAL;
					default:   dec_o.aluop = ALU_NOP;
				endcase
				if (dec_o.aluop != ALU_NOP) begin
					dec_o.reg1_rd = 1'b1;
					dec_o.br_kind = rt[0] ? BR_GEZ : BR_LTZ;
					dec_o.link = rt[4]; // the -al forms
					dec_o.wreg = rt[4];
					if (rt[4]) begin
						dec_o.wd = LINK_REG;
					end
				end
			end
			default: begin
			end
		endcase
		if (inst_i == '0) begin
			dec_o = '0; // canonical nop, no write to r0
		end
		dec_o.alusel = class_of(dec_o.aluop);
		assert final (!(dec_o.link && dec_o.wreg && dec_o.wd == '0))
			else $error("link write to r0, inst %h", inst_i);
	end

endmodule

`default_nettype wire

//--- source/id_operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module id_operand_select (
	input  logic                   rd_i,
	input  mips_id_pkg::reg_addr_t addr_i,
	input  mips_id_pkg::word_t     rf_data_i,
	input  mips_id_pkg::word_t     imm_i,
	input  mips_id_pkg::fwd_t      ex_fwd_i,
	input  mips_id_pkg::fwd_t      mem_fwd_i,
	output mips_id_pkg::word_t     op_o
);

	logic ex_hit;
	logic mem_hit;

	assign ex_hit  = ex_fwd_i.wreg && (ex_fwd_i.wd == addr_i);
	assign mem_hit = mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

	always_comb begin
		if (!rd_i) begin
			op_o = imm_i;
		end else if (ex_hit) begin
			op_o = ex_fwd_i.wdata; // youngest result first
		end else if (mem_hit) begin
			op_o = mem_fwd_i.wdata;
		end else begin
			op_o = rf_data_i;
		end
	end

	always_comb begin
		assert final (rd_i || op_o == imm_i)
			else $error("operand %h differs from immediate %h", op_o, imm_i);
	end

endmodule

`default_nettype wire

//--- source/id_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module id_branch_unit (
	input  mips_id_pkg::word_t    pc_i,
	input  mips_id_pkg::word_t    inst_i,
	input  mips_id_pkg::br_kind_e br_kind_i,
	input  logic                  link_i,
	input  mips_id_pkg::word_t    op1_i,
	input  mips_id_pkg::word_t    op2_i,
	output mips_id_pkg::branch_t  branch_o,
	output mips_id_pkg::word_t    link_addr_o
);
	import mips_id_pkg::*;

	word_t pc_plus_4;
	word_t pc_plus_8;
	word_t br_offset;
	word_t target;
	logic  taken;

	assign pc_plus_4 = pc_i + 32'd4;
	assign pc_plus_8 = pc_i + 32'd8; // return past the delay slot
	assign br_offset = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};

	always_comb begin
		case (br_kind_i)
			BR_JUMP_ABS, BR_JUMP_REG: taken = 1'b1;
			BR_EQ:   taken = (op1_i == op2_i);
			BR_NE:   taken = (op1_i != op2_i);
			BR_GTZ:  taken = !op1_i[31] && (op1_i != '0);
			BR_LEZ:  taken = op1_i[31] || (op1_i == '0);
			BR_GEZ:  taken = !op1_i[31];
			BR_LTZ:  taken = op1_i[31];
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (!taken) begin
			target = '0;
		end else if (br_kind_i == BR_JUMP_ABS) begin
			target = {pc_plus_4[31:28], inst_i[25:0], 2'b00}; // same 256MB region
		end else if (br_kind_i == BR_JUMP_REG) begin
			target = op1_i;
		end else begin
			target = pc_plus_4 + br_offset;
		end
	end

	assign branch_o = '{flag: taken, target: target, next_in_dslot: taken};
	assign link_addr_o = link_i ? pc_plus_8 : '0;

	always_comb begin
		assert final (branch_o.next_in_dslot == branch_o.flag &&
			(branch_o.flag || branch_o.target == '0))
			else $error("branch bundle inconsistent, kind %0d", br_kind_i);
	end

endmodule

`default_nettype wire

//--- source/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
	input  logic                clk,
	input  logic                rst_n_i,
	input  mips_id_pkg::id_ex_t d_i,
	output mips_id_pkg::id_ex_t q_o
);

	// whole bundle clears so EX sees a bubble out of reset
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			q_o <= '0;
		end else begin
			q_o <= d_i;
		end
	end

	// no write can leak into EX while the core is held in reset
	assert property (@(posedge clk) !rst_n_i |=> !q_o.wreg)
		else $error("id_ex wreg set during reset");

endmodule

`default_nettype wire

//--- source/id_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_top (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  mips_id_pkg::word_t     pc_i,
	input  mips_id_pkg::word_t     inst_i,
	input  mips_id_pkg::word_t     reg1_data_i,
	input  mips_id_pkg::word_t     reg2_data_i,
	input  mips_id_pkg::fwd_t      ex_fwd_i,
	input  mips_id_pkg::fwd_t      mem_fwd_i,
	input  logic                   in_dslot_i,
	output logic                   reg1_rd_o,
	output mips_id_pkg::reg_addr_t reg1_addr_o,
	output logic                   reg2_rd_o,
	output mips_id_pkg::reg_addr_t reg2_addr_o,
	output mips_id_pkg::branch_t   branch_o,
	output mips_id_pkg::id_ex_t    id_ex_o
);
	import mips_id_pkg::*;

	decode_t dec;
	word_t   op1;
	word_t   op2;
	word_t   link_addr;
	id_ex_t  id_ex_d;

	id_decoder u_decoder (
		.inst_i (inst_i),
		.dec_o  (dec)
	);

	assign reg1_rd_o   = dec.reg1_rd;
	assign reg1_addr_o = dec.reg1_addr;
	assign reg2_rd_o   = dec.reg2_rd;
	assign reg2_addr_o = dec.reg2_addr;

	id_operand_select u_op1_sel (
		.rd_i      (dec.reg1_rd),
		.addr_i    (dec.reg1_addr),
		.rf_data_i (reg1_data_i),
		.imm_i     (dec.imm),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.op_o      (op1)
	);

	id_operand_select u_op2_sel (
		.rd_i      (dec.reg2_rd),
		.addr_i    (dec.reg2_addr),
		.rf_data_i (reg2_data_i),
		.imm_i     (dec.imm),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.op_o      (op2)
	);

	id_branch_unit u_branch (
		.pc_i        (pc_i),
		.inst_i      (inst_i),
		.br_kind_i   (dec.br_kind),
		.link_i      (dec.link),
		.op1_i       (op1), // forwarded, so branches see fresh values
		.op2_i       (op2),
		.branch_o    (branch_o),
		.link_addr_o (link_addr)
	);

	assign id_ex_d = '{
		aluop:     dec.aluop,
		alusel:    dec.alusel,
		op1:       op1,
		op2:       op2,
		wd:        dec.wd,
		wreg:      dec.wreg,
		link_addr: link_addr,
		in_dslot:  in_dslot_i
	};

	id_ex_reg u_id_ex (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.d_i     (id_ex_d),
		.q_o     (id_ex_o)
	);

endmodule

`default_nettype wire

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic clk_o,
	output logic rst_n_o
);

	localparam int HALF_PERIOD  = 20;
	localparam int RESET_CYCLES = 8;

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD) clk_o = ~clk_o;
	end

	initial begin
		rst_n_o = 1'b1;
		#1;
		rst_n_o = 1'b0; // falling edge clears the flops right away
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

//--- sim/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;
	import mips_id_pkg::*;

	typedef struct packed {
		logic      r1_rd;
		reg_addr_t r1_addr;
		logic      r2_rd;
		reg_addr_t r2_addr;
		branch_t   br;
		id_ex_t    idex;
	} expect_t;

	localparam int N_ALU = 64;
	localparam int N_FWD = 48;
	localparam int N_BR  = 48;
	localparam int N_JMP = 24;
	localparam int N_BAD = 8;
	localparam int TIMEOUT_CYCLES = 10 + N_ALU + N_FWD + N_BR + N_JMP + N_BAD + 2 * 6 + 50;

	localparam logic [5:0] REG_FNS [16] = '{FN_OR, FN_AND, FN_XOR, FN_NOR, FN_SLL, FN_SRL,
		FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU};
	localparam logic [5:0] IMM_OPS [8] = '{OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_ADDI,
		OP_ADDIU, OP_SLTI, OP_SLTIU};
	localparam logic [5:0] BR_OPS [4] = '{OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ};
	localparam logic [4:0] RI_RTS [4] = '{RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL};
	localparam logic [5:0] BAD_OPS [4] = '{6'b100011, 6'b101011, 6'b010000, 6'b011100};

	logic      clk;
	logic      rst_n;
	word_t     pc;
	word_t     inst;
	word_t     reg1_data;
	word_t     reg2_data;
	fwd_t      ex_fwd;
	fwd_t      mem_fwd;
	logic      in_dslot;
	logic      reg1_rd;
	reg_addr_t reg1_addr;
	logic      reg2_rd;
	reg_addr_t reg2_addr;
	branch_t   branch;
	id_ex_t    id_ex;

	word_t       regs [32];
	logic [31:0] rng_state = 32'd76;
	int          errors = 0;
	int          cycles = 0;
	expect_t     exp_now;
	id_ex_t      exp_prev;
	logic [11:0] rd_ports;
	logic [11:0] exp_ports;

	tb_clk_gen u_clk_gen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	id_stage_top u_id_stage_top (
		.clk         (clk),
		.rst_n_i     (rst_n),
		.pc_i        (pc),
		.inst_i      (inst),
		.reg1_data_i (reg1_data),
		.reg2_data_i (reg2_data),
		.ex_fwd_i    (ex_fwd),
		.mem_fwd_i   (mem_fwd),
		.in_dslot_i  (in_dslot),
		.reg1_rd_o   (reg1_rd),
		.reg1_addr_o (reg1_addr),
		.reg2_rd_o   (reg2_rd),
		.reg2_addr_o (reg2_addr),
		.branch_o    (branch),
		.id_ex_o     (id_ex)
	);

	// register file model, r0 hardwired
	assign reg1_data = (reg1_addr == 5'd0) ? '0 : regs[reg1_addr];
	assign reg2_data = (reg2_addr == 5'd0) ? '0 : regs[reg2_addr];

	function automatic word_t xorshift_next();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic word_t random_pc();
		word_t w;
		w = xorshift_next();
		return {w[31:2], 2'b00};
	endfunction

	function automatic word_t source_value(input reg_addr_t a, input fwd_t ex, input fwd_t mem);
		if (ex.wreg && ex.wd == a) begin
			return ex.wdata;
		end
		if (mem.wreg && mem.wd == a) begin
			return mem.wdata;
		end
		return (a == 5'd0) ? '0 : regs[a];
	endfunction

	function automatic expect_t predict(input word_t ins, input word_t pc_v, input fwd_t ex,
			input fwd_t mem, input logic dslot);
		expect_t    e;
		logic [5:0] op;
		logic [5:0] fn;
		reg_addr_t  rs;
		reg_addr_t  rt;
		word_t      imm;
		word_t      pc4;
		word_t      tgt;
		logic       link;
		logic       taken;
		op = ins[31:26];
		fn = ins[5:0];
		rs = ins[25:21];
		rt = ins[20:16];
		pc4 = pc_v + 32'd4;
		imm = '0;
		link = 1'b0;
		taken = 1'b0;
		e = '0;
		e.r1_addr = rs;
		e.r2_addr = rt;
		e.idex.wd = ins[15:11];
		case (op)
			OP_SPECIAL: begin
				e.r1_rd = 1'b1;
				e.r2_rd = 1'b1;
				e.idex.wreg = 1'b1;
				case (fn)
					FN_OR:           e.idex.aluop = ALU_OR;
					FN_AND:          e.idex.aluop = ALU_AND;
					FN_XOR:          e.idex.aluop = ALU_XOR;
					FN_NOR:          e.idex.aluop = ALU_NOR;
					FN_SLL, FN_SLLV: e.idex.aluop = ALU_SLL;
					FN_SRL, FN_SRLV: e.idex.aluop = ALU_SRL;
					FN_SRA, FN_SRAV: e.idex.aluop = ALU_SRA;
					FN_ADD:          e.idex.aluop = ALU_ADD;
					FN_ADDU:         e.idex.aluop = ALU_ADDU;
					FN_SUB:          e.idex.aluop = ALU_SUB;
					FN_SUBU:         e.idex.aluop = ALU_SUBU;
					FN_SLT:          e.idex.aluop = ALU_SLT;
					FN_SLTU:         e.idex.aluop = ALU_SLTU;
					FN_JR:           e.idex.aluop = ALU_JR;
					FN_JALR:         e.idex.aluop = ALU_JALR;
					default: begin
						e.r1_rd = 1'b0;
						e.r2_rd = 1'b0;
						e.idex.wreg = 1'b0;
					end
				endcase
				case (fn)
					FN_OR, FN_AND, FN_XOR, FN_NOR: e.idex.alusel = SEL_LOGIC;
					FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV: e.idex.alusel = SEL_SHIFT;
					FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU: e.idex.alusel = SEL_ARITH;
					FN_JR, FN_JALR: e.idex.alusel = SEL_JUMP_BRANCH;
					default: e.idex.alusel = SEL_NOP;
				endcase
				if (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA) begin
					e.r1_rd = 1'b0;
					imm = {27'd0, ins[10:6]}; // shift amount as op1
				end
				if (fn == FN_JR || fn == FN_JALR) begin
					e.r2_rd = 1'b0;
					e.idex.wreg = (fn == FN_JALR) && (ins[15:11] != 5'd0);
					link = (fn == FN_JALR);
				end
			end
			OP_ORI, OP_ANDI, OP_XORI, OP_LUI: begin
				e.r1_rd = 1'b1;
				e.idex.wreg = 1'b1;
				e.idex.wd = rt;
				e.idex.alusel = SEL_LOGIC;
				e.idex.aluop = (op == OP_ANDI) ? ALU_AND : (op == OP_XORI) ? ALU_XOR : ALU_OR;
				imm = (op == OP_LUI) ? {ins[15:0], 16'h0000} : {16'h0000, ins[15:0]};
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				e.r1_rd = 1'b1;
				e.idex.wreg = 1'b1;
				e.idex.wd = rt;
				e.idex.alusel = SEL_ARITH;
				imm = {{16{ins[15]}}, ins[15:0]};
				case (op)
					OP_ADDI:  e.idex.aluop = ALU_ADDI;
					OP_ADDIU: e.idex.aluop = ALU_ADDIU;
					OP_SLTI:  e.idex.aluop = ALU_SLT;
					default:  e.idex.aluop = ALU_SLTU;
				endcase
			end
			OP_J, OP_JAL: begin
				e.idex.alusel = SEL_JUMP_BRANCH;
				e.idex.aluop = (op == OP_J) ? ALU_J : ALU_JAL;
				if (op == OP_JAL) begin
					e.idex.wd = LINK_REG;
					e.idex.wreg = 1'b1;
					link = 1'b1;
				end
			end
			OP_BEQ, OP_BNE: begin
				e.r1_rd = 1'b1;
				e.r2_rd = 1'b1;
				e.idex.alusel = SEL_JUMP_BRANCH;
				e.idex.aluop = (op == OP_BEQ) ? ALU_BEQ : ALU_BNE;
			end
			OP_BGTZ, OP_BLEZ: begin
				e.r1_rd = 1'b1;
				e.idex.alusel = SEL_JUMP_BRANCH;
				e.idex.aluop = (op == OP_BGTZ) ? ALU_BGTZ : ALU_BLEZ;
			end
			OP_REGIMM: begin
				case (rt)
					RT_BLTZ:   e.idex.aluop = ALU_BLTZ;
					RT_BGEZ:   e.idex.aluop = ALU_BGEZ;
					RT_BLTZAL: e.idex.aluop = ALU_BLTZAL;
					RT_BGEZAL: e.idex.aluop = ALU_BGEZAL;
					default:   e.idex.aluop = ALU_NOP;
				endcase
				if (e.idex.aluop != ALU_NOP) begin
					e.r1_rd = 1'b1;
					e.idex.alusel = SEL_JUMP_BRANCH;
				end
				if (rt == RT_BLTZAL || rt == RT_BGEZAL) begin
					e.idex.wd = LINK_REG;
					e.idex.wreg = 1'b1;
					link = 1'b1;
				end
			end
			default: begin
			end
		endcase
		e.idex.op1 = e.r1_rd ? source_value(rs, ex, mem) : imm;
		e.idex.op2 = e.r2_rd ? source_value(rt, ex, mem) : imm;
		tgt = pc4 + {{14{ins[15]}}, ins[15:0], 2'b00};
		case (e.idex.aluop)
			ALU_J, ALU_JAL: begin
				taken = 1'b1;
				tgt = {pc4[31:28], ins[25:0], 2'b00};
			end
			ALU_JR, ALU_JALR: begin
				taken = 1'b1;
				tgt = e.idex.op1;
			end
			ALU_BEQ:              taken = (e.idex.op1 == e.idex.op2);
			ALU_BNE:              taken = (e.idex.op1 != e.idex.op2);
			ALU_BGTZ:             taken = ($signed(e.idex.op1) > 0);
			ALU_BLEZ:             taken = ($signed(e.idex.op1) <= 0);
			ALU_BGEZ, ALU_BGEZAL: taken = ($signed(e.idex.op1) >= 0);
			ALU_BLTZ, ALU_BLTZAL: taken = ($signed(e.idex.op1) < 0);
			default:              taken = 1'b0;
		endcase
		e.br.flag = taken;
		e.br.target = taken ? tgt : '0;
		e.br.next_in_dslot = taken;
		e.idex.link_addr = link ? pc_v + 32'd8 : '0;
		e.idex.in_dslot = dslot;
		if (ins == '0) begin
			e = '0; // the all-zero word is a plain nop
			e.idex.in_dslot = dslot;
		end
		return e;
	endfunction

	always_comb exp_now = predict(inst, pc, ex_fwd, mem_fwd, in_dslot);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_prev <= '0;
		end else begin
			exp_prev <= exp_now.idex; // what ID/EX holds after this edge
		end
	end

	assign rd_ports  = {reg1_rd, reg1_addr, reg2_rd, reg2_addr};
	assign exp_ports = {exp_now.r1_rd, exp_now.r1_addr, exp_now.r2_rd, exp_now.r2_addr};

	assert property (@(posedge clk) branch == exp_now.br)
		else begin
			errors = errors + 1;
			$display("** Error branch_o: got %h, expected %h", $sampled(branch),
				$sampled(exp_now.br));
		end

	assert property (@(posedge clk) rd_ports == exp_ports)
		else begin
			errors = errors + 1;
			$display("** Error read ports {rd1,addr1,rd2,addr2}: got %h, expected %h",
				$sampled(rd_ports), $sampled(exp_ports));
		end

	assert property (@(posedge clk) id_ex == exp_prev)
		else begin
			errors = errors + 1;
			$display("** Error id_ex_o: got %h, expected %h", $sampled(id_ex),
				$sampled(exp_prev));
		end

	assert property (@(posedge clk) !rst_n |-> (id_ex == '0) && !branch.flag)
		else begin
			errors = errors + 1;
			$display("** Error id_ex_o in reset: got %h, expected 0 (branch_o.flag %h)",
				$sampled(id_ex), $sampled(branch.flag));
		end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic drive(input word_t ins, input word_t pc_v, input fwd_t ex, input fwd_t mem,
			input logic dslot);
		@(negedge clk);
		inst = ins;
		pc = pc_v;
		ex_fwd = ex;
		mem_fwd = mem;
		in_dslot = dslot;
	endtask

	// one bubble so the last bundle gets compared in ID/EX
	task automatic end_test(input string name, input int first_err, input int count);
		drive('0, '0, '0, '0, 1'b0);
		@(negedge clk);
		$display("test %-8s %0d instructions, %0d errors", name, count, errors - first_err);
	endtask

	task automatic run_reset_check();
		int first;
		first = errors;
		wait (rst_n === 1'b0);
		wait (rst_n === 1'b1);
		end_test("reset", first, 0);
	endtask

	task automatic run_alu_ops();
		int    first;
		word_t r;
		word_t ins;
		first = errors;
		for (int i = 0; i < N_ALU; i++) begin
			r = xorshift_next();
			if (r[31]) begin
				ins = {OP_SPECIAL, r[25:6], REG_FNS[r[29:26]]};
			end else begin
				ins = {IMM_OPS[r[28:26]], r[25:0]};
			end
			drive(ins, random_pc(), '0, '0, 1'b0);
		end
		end_test("alu", first, N_ALU);
	endtask

	task automatic run_forwarding();
		int    first;
		word_t r;
		word_t ins;
		fwd_t  ex;
		fwd_t  mem;
		first = errors;
		for (int i = 0; i < N_FWD; i++) begin
			r = xorshift_next();
			// few registers so EX and MEM hits overlap often
			ins = {OP_SPECIAL, 3'b000, r[1:0], 3'b000, r[3:2], 5'd4, 5'd0, REG_FNS[r[13:10]]};
			ex = '{wreg: r[4], wd: {3'b000, r[6:5]}, wdata: xorshift_next()};
			mem = '{wreg: r[7], wd: {3'b000, r[9:8]}, wdata: xorshift_next()};
			drive(ins, random_pc(), ex, mem, 1'b0);
		end
		end_test("forward", first, N_FWD);
	endtask

	task automatic run_branches();
		int    first;
		word_t r;
		word_t off;
		word_t ins;
		first = errors;
		for (int i = 0; i < N_BR; i++) begin
			r = xorshift_next();
			off = xorshift_next();
			if (r[31]) begin
				ins = {OP_REGIMM, 3'b000, r[1:0], RI_RTS[r[5:4]], off[15:0]};
			end else begin
				ins = {BR_OPS[r[5:4]], 3'b000, r[1:0], 3'b000, r[3:2], off[15:0]};
			end
			drive(ins, random_pc(), '0, '0, 1'b0);
		end
		end_test("branch", first, N_BR);
	endtask

	task automatic run_jumps();
		int    first;
		word_t r;
		word_t ins;
		first = errors;
		for (int i = 0; i < N_JMP; i++) begin
			r = xorshift_next();
			case (r[31:30])
				2'd0:    ins = {OP_J, r[25:0]};
				2'd1:    ins = {OP_JAL, r[25:0]};
				2'd2:    ins = {OP_SPECIAL, r[25:21], 15'd0, FN_JR};
				default: ins = {OP_SPECIAL, r[25:21], 5'd0, r[15:11], 5'd0, FN_JALR};
			endcase
			drive(ins, random_pc(), '0, '0, r[29]);
		end
		end_test("jump", first, N_JMP);
	endtask

	task automatic run_unknown_ops();
		int    first;
		word_t r;
		first = errors;
		for (int i = 0; i < N_BAD; i++) begin
			r = xorshift_next();
			drive({BAD_OPS[r[31:30]], r[25:0]}, random_pc(), '0, '0, 1'b0);
		end
		end_test("unknown", first, N_BAD);
	endtask

	initial begin
		pc = '0;
		inst = '0;
		ex_fwd = '0;
		mem_fwd = '0;
		in_dslot = 1'b0;
		for (int i = 0; i < 32; i++) begin
			regs[i] = xorshift_next();
		end
		run_reset_check();
		run_alu_ops();
		run_forwarding();
		run_branches();
		run_jumps();
		run_unknown_ops();
		$display("summary: 6 tests, %0d cycles, %0d errors", cycles, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
source/mips_id_pkg.sv
source/id_decoder.sv
source/id_operand_select.sv
source/id_branch_unit.sv
source/id_ex_reg.sv
source/id_stage_top.sv
sim/tb_clk_gen.sv
sim/tb_id_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard source/*.sv sim/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
